// File: logic/tcore_isa_pkg.sv
/*
 * tcore instruction set definitions
 * field layout, word widths, opcodes and ALU op codes
 */
package tcore_isa_pkg;

	// ------------------------------
	// widths, all fixed by the format
	// ------------------------------
	localparam int DAT_W       = 16;
	localparam int INS_W       = 16;
	localparam int OPC_W       = 4;
	localparam int REG_IDX_W   = 3;
	localparam int IMEM_ADDR_W = 8;
	localparam int DMEM_ADDR_W = 8;
	localparam int IMM_W       = 8;
	localparam int ALU_OP_W    = 3;

	localparam int NUM_GPR   = 8;
	// shift-add steps for one multiply
	localparam int MUL_STEPS = 16;

	// field positions inside the instruction word
	localparam int OPC_LSB = 12;
	localparam int RD_LSB  = 9;
	localparam int RS_LSB  = 6;
	localparam int RT_LSB  = 3;

	typedef logic [DAT_W-1:0]       dat_t;
	typedef logic [INS_W-1:0]       ins_t;
	typedef logic [OPC_W-1:0]       opcode_t;
	typedef logic [REG_IDX_W-1:0]   reg_idx_t;
	typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;
	typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;
	// zero-extended when used as data
	typedef logic [IMM_W-1:0]       imm_t;
	typedef logic [ALU_OP_W-1:0]    alu_op_t;

	// ------------------------------
	// opcodes, unlisted codes act as nop
	// ------------------------------
	localparam opcode_t OP_NOP  = 4'd0;
	localparam opcode_t OP_MOVI = 4'd1;
	localparam opcode_t OP_LD   = 4'd2;
	localparam opcode_t OP_ST   = 4'd3;
	localparam opcode_t OP_ADD  = 4'd4;
	localparam opcode_t OP_SUB  = 4'd5;
	localparam opcode_t OP_MUL  = 4'd6;
	localparam opcode_t OP_AND  = 4'd7;
	localparam opcode_t OP_XOR  = 4'd8;
	localparam opcode_t OP_JMP  = 4'd9;
	localparam opcode_t OP_HALT = 4'd15;

	// alu operation select
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_MUL = 3'd2;
	localparam alu_op_t ALU_AND = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;

endpackage

// File: logic/tcore_ctrl_pkg.sv
/*
 * tcore control definitions
 * sequencer states and the structs passed between core blocks
 */
package tcore_ctrl_pkg;
	import tcore_isa_pkg::*;

	// instruction sequencer FSM
	typedef enum logic [2:0] {
		S_FETCH,
		S_INS_WAIT,
		S_EXEC,
		S_WAIT_DONE,
		S_HALT
	} seq_state_e;

	// ------------------------------
	// decoded instruction
	// ------------------------------
	typedef struct packed {
		reg_idx_t rd;
		reg_idx_t rd_idx_a;  // rd for st, rs for alu ops
		reg_idx_t rd_idx_b;  // always rt
		logic     alu_en;
		alu_op_t  alu_op;
		logic     is_movi;
		logic     is_ld;
		logic     is_st;
		logic     is_jmp;
		logic     is_halt;
		imm_t     field;     // imm, data addr or jump target
	} dec_ctrl_t;

	// register file write port
	typedef struct packed {
		logic     en;
		reg_idx_t idx;
		dat_t     dat;
	} gprf_wr_t;

	// data memory request, rw 1 = read
	typedef struct packed {
		logic       en_b;
		logic       rw;
		dmem_addr_t addr;
		dat_t       wdat;
	} dmem_req_t;

endpackage

// File: logic/ins_sequencer.sv
/*
 * instruction sequencer
 * pc, fetch strobe, instruction register, jump and halt FSM
 */
module ins_sequencer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      t_cs,
	input  tcore_isa_pkg::ins_t       ins_mem_dat,
	output logic                      ins_mem_en_b,
	output tcore_isa_pkg::imem_addr_t ins_mem_addr,
	input  tcore_ctrl_pkg::dec_ctrl_t ctrl,
	input  logic                      op_done,
	output tcore_isa_pkg::ins_t       ins_reg,
	output logic                      exec_start,
	output logic                      halt
);
	import tcore_isa_pkg::*;
	import tcore_ctrl_pkg::*;

	seq_state_e state_q;
	imem_addr_t pc_q;
	// low through reset, high from the first clock after
	logic       armed_q;
	logic       fetch;

	// ------------------------------
	// memory side
	// ------------------------------
	// chip select low stalls the fetch, nothing else does
	assign fetch        = (state_q == S_FETCH) && t_cs && armed_q;
	assign ins_mem_en_b = ~fetch;
	assign ins_mem_addr = pc_q;

	// one cycle pulse, ctrl is valid from the latched word here
	assign exec_start = (state_q == S_EXEC);
	assign halt       = (state_q == S_HALT);

	// ------------------------------
	// state machine
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= S_FETCH;
			pc_q    <= '0;
			ins_reg <= '0;
			armed_q <= 1'b0;
		end else begin
			armed_q <= 1'b1;
			case (state_q)
				S_FETCH: begin
					if (fetch) begin
						state_q <= S_INS_WAIT;
					end
				end
				S_INS_WAIT: begin
					// memory output valid the cycle after the strobe
					ins_reg <= ins_mem_dat;
					state_q <= S_EXEC;
				end
				S_EXEC: begin
					state_q <= S_WAIT_DONE;
				end
				S_WAIT_DONE: begin
					if (op_done) begin
						if (ctrl.is_halt) begin
							state_q <= S_HALT;
						end else begin
							state_q <= S_FETCH;
							// jump target or next word
							pc_q    <= ctrl.is_jmp ? imem_addr_t'(ctrl.field) : pc_q + 1'b1;
						end
					end
				end
				default: begin
					// halted, only reset leaves
					state_q <= S_HALT;
				end
			endcase
		end
	end

endmodule

// File: logic/ins_decoder.sv
/*
 * instruction decoder
 * splits the instruction register into fields and control flags
 */
module ins_decoder (
	input  tcore_isa_pkg::ins_t       ins,
	output tcore_ctrl_pkg::dec_ctrl_t ctrl
);
	import tcore_isa_pkg::*;

	opcode_t opc;
	reg_idx_t rd;

	assign opc = opcode_t'(ins[OPC_LSB +: OPC_W]);
	assign rd  = ins[RD_LSB +: REG_IDX_W];

	always_comb begin
		// every flag clear unless the opcode says otherwise
		ctrl          = '0;
		ctrl.rd       = rd;
		ctrl.rd_idx_a = ins[RS_LSB +: REG_IDX_W];
		ctrl.rd_idx_b = ins[RT_LSB +: REG_IDX_W];
		ctrl.field    = ins[IMM_W-1:0];
		ctrl.alu_op   = ALU_ADD;

		case (opc)
			OP_NOP: begin
			end
			OP_MOVI: ctrl.is_movi = 1'b1;
			OP_LD:   ctrl.is_ld   = 1'b1;
			OP_ST: begin
				ctrl.is_st    = 1'b1;
				// store data comes out of port a
				ctrl.rd_idx_a = rd;
			end
			// register-register alu group
			OP_ADD: begin
				ctrl.alu_en = 1'b1;
				ctrl.alu_op = ALU_ADD;
			end
			OP_SUB: begin
				ctrl.alu_en = 1'b1;
				ctrl.alu_op = ALU_SUB;
			end
			OP_MUL: begin
				ctrl.alu_en = 1'b1;
				ctrl.alu_op = ALU_MUL;
			end
			OP_AND: begin
				ctrl.alu_en = 1'b1;
				ctrl.alu_op = ALU_AND;
			end
			OP_XOR: begin
				ctrl.alu_en = 1'b1;
				ctrl.alu_op = ALU_XOR;
			end
			OP_JMP:  ctrl.is_jmp  = 1'b1;
			OP_HALT: ctrl.is_halt = 1'b1;
			default: begin
				// unused codes run as nop
			end
		endcase
	end

endmodule

// File: logic/gprf.sv
/*
 * general purpose register file
 * eight words, two combinational reads, one clocked write
 */
module gprf (
	input  logic                        clk,
	input  logic                        rst_n,
	input  tcore_isa_pkg::reg_idx_t     rd_idx_a,
	input  tcore_isa_pkg::reg_idx_t     rd_idx_b,
	output tcore_isa_pkg::dat_t         rd_dat_a,
	output tcore_isa_pkg::dat_t         rd_dat_b,
	input  tcore_ctrl_pkg::gprf_wr_t    wr
);
	import tcore_isa_pkg::*;

	dat_t regs_q [NUM_GPR];

	// read ports, no bypass of a same-cycle write
	assign rd_dat_a = regs_q[rd_idx_a];
	assign rd_dat_b = regs_q[rd_idx_b];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_GPR; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr.en) begin
			regs_q[wr.idx] <= wr.dat;
		end
	end

endmodule

// File: logic/alu.sv
/*
 * ALU
 * one cycle add, sub, and, xor; iterative shift-add multiply
 */
module alu (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  tcore_isa_pkg::alu_op_t op,
	input  tcore_isa_pkg::dat_t    opa,
	input  tcore_isa_pkg::dat_t    opb,
	output tcore_isa_pkg::dat_t    result,
	output logic                   done
);
	import tcore_isa_pkg::*;

	alu_op_t    op_q;
	dat_t       opa_q;
	dat_t       opb_q;
	dat_t       acc_q;
	dat_t       partial;
	dat_t       mul_sum;
	logic       busy_q;
	logic       quick_q;
	logic [3:0] step_q;

	// ------------------------------
	// multiply datapath
	// ------------------------------
	// one partial product per step, low 16 bits only
	assign partial = opb_q[0] ? opa_q : '0;
	// last step is folded in combinationally
	assign mul_sum = acc_q + partial;

	always_comb begin
		case (op_q)
			ALU_SUB: result = opa_q - opb_q;
			ALU_MUL: result = mul_sum;
			ALU_AND: result = opa_q & opb_q;
			ALU_XOR: result = opa_q ^ opb_q;
			default: result = opa_q + opb_q;
		endcase
	end

	// quick ops finish next cycle, mul after all steps
	assign done = quick_q | (busy_q & (step_q == 4'(MUL_STEPS - 1)));

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q  <= 1'b0;
			quick_q <= 1'b0;
			step_q  <= '0;
		end else begin
			quick_q <= start && (op != ALU_MUL);
			if (start) begin
				busy_q <= (op == ALU_MUL);
				step_q <= '0;
			end else if (busy_q) begin
				step_q <= step_q + 1'b1;
				if (step_q == 4'(MUL_STEPS - 1)) begin
					busy_q <= 1'b0;
				end
			end
		end
	end

	// operands latched on start, then shifted for mul
	always_ff @(posedge clk) begin
		if (start) begin
			op_q  <= op;
			opa_q <= opa;
			opb_q <= opb;
			acc_q <= '0;
		end else if (busy_q) begin
			acc_q <= mul_sum;
			opa_q <= opa_q << 1;
			opb_q <= opb_q >> 1;
		end
	end

endmodule

// File: logic/mem_writeback.sv
/*
 * memory access and write-back
 * data memory strobes, register write source and completion pulse
 */
module mem_writeback (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      exec_start,
	input  tcore_ctrl_pkg::dec_ctrl_t ctrl,
	input  tcore_isa_pkg::dat_t       st_dat,
	input  tcore_isa_pkg::dat_t       alu_result,
	input  logic                      alu_done,
	input  tcore_isa_pkg::dat_t       dmem_rdat,
	output tcore_ctrl_pkg::dmem_req_t dmem_req,
	output tcore_ctrl_pkg::gprf_wr_t  gprf_wr,
	output logic                      op_done
);
	import tcore_isa_pkg::*;

	// PH_MEM drives the strobe, PH_WB writes rd and completes
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_MEM,
		PH_ALU,
		PH_WB
	} wb_phase_e;

	wb_phase_e ph_q;
	dat_t      res_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ph_q <= PH_IDLE;
		end else begin
			case (ph_q)
				PH_IDLE: begin
					if (exec_start) begin
						if (ctrl.is_ld || ctrl.is_st) ph_q <= PH_MEM;
						else if (ctrl.alu_en)         ph_q <= PH_ALU;
						else                          ph_q <= PH_WB;
					end
				end
				// st ends here, ld waits one cycle for read data
				PH_MEM:  ph_q <= ctrl.is_ld ? PH_WB : PH_IDLE;
				PH_ALU:  if (alu_done) ph_q <= PH_WB;
				default: ph_q <= PH_IDLE;
			endcase
		end
	end

	// alu result held for the write-back cycle
	always_ff @(posedge clk) begin
		if (ph_q == PH_ALU && alu_done) begin
			res_q <= alu_result;
		end
	end

	// ------------------------------
	// outputs
	// ------------------------------
	assign op_done = (ph_q == PH_WB) || (ph_q == PH_MEM && ctrl.is_st);

	always_comb begin
		dmem_req.en_b = (ph_q != PH_MEM);
		// read level except during a store
		dmem_req.rw   = !(ph_q == PH_MEM && ctrl.is_st);
		dmem_req.addr = dmem_addr_t'(ctrl.field);
		dmem_req.wdat = st_dat;

		gprf_wr.en  = (ph_q == PH_WB) && (ctrl.is_movi || ctrl.is_ld || ctrl.alu_en);
		gprf_wr.idx = ctrl.rd;
		// source select: immediate, memory word or alu
		if (ctrl.is_movi)    gprf_wr.dat = dat_t'(ctrl.field);
		else if (ctrl.is_ld) gprf_wr.dat = dmem_rdat;
		else                 gprf_wr.dat = res_q;
	end

endmodule

// File: logic/tcore_top.sv
/*
 * tcore core top
 * sequencer, decoder, register file, ALU and write-back,
 * instruction and data memories sit outside
 */
module tcore_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      t_cs,
	// instruction memory
	input  tcore_isa_pkg::ins_t       ins_mem_dat,
	output logic                      ins_mem_en_b,
	output tcore_isa_pkg::imem_addr_t ins_mem_addr,
	// data memory 1, rw 1 = read
	output logic                      dat_mem1_rw,
	output logic                      dat_mem1_en_b,
	output tcore_isa_pkg::dmem_addr_t dat_mem1_addr,
	input  tcore_isa_pkg::dat_t       mem1_to_wrp_dat,
	output tcore_isa_pkg::dat_t       wrp_to_mem1_dat,
	output logic                      halt
);
	import tcore_isa_pkg::*;
	import tcore_ctrl_pkg::*;

	ins_t      ins_reg;
	dec_ctrl_t ctrl;
	logic      exec_start;
	logic      op_done;
	dat_t      rd_dat_a;
	dat_t      rd_dat_b;
	gprf_wr_t  gprf_wr;
	dat_t      alu_result;
	logic      alu_done;
	dmem_req_t dmem_req;

	// ------------------------------
	// fetch and decode
	// ------------------------------
	ins_sequencer u_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.t_cs         (t_cs),
		.ins_mem_dat  (ins_mem_dat),
		.ins_mem_en_b (ins_mem_en_b),
		.ins_mem_addr (ins_mem_addr),
		.ctrl         (ctrl),
		.op_done      (op_done),
		.ins_reg      (ins_reg),
		.exec_start   (exec_start),
		.halt         (halt)
	);

	ins_decoder u_dec (
		.ins  (ins_reg),
		.ctrl (ctrl)
	);

	// ------------------------------
	// registers and execute
	// ------------------------------
	gprf u_gprf (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_idx_a (ctrl.rd_idx_a),
		.rd_idx_b (ctrl.rd_idx_b),
		.rd_dat_a (rd_dat_a),
		.rd_dat_b (rd_dat_b),
		.wr       (gprf_wr)
	);

	alu u_alu (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (exec_start),
		.op     (ctrl.alu_op),
		.opa    (rd_dat_a),
		.opb    (rd_dat_b),
		.result (alu_result),
		.done   (alu_done)
	);

	// port a carries the store data
	mem_writeback u_wb (
		.clk        (clk),
		.rst_n      (rst_n),
		.exec_start (exec_start),
		.ctrl       (ctrl),
		.st_dat     (rd_dat_a),
		.alu_result (alu_result),
		.alu_done   (alu_done),
		.dmem_rdat  (mem1_to_wrp_dat),
		.dmem_req   (dmem_req),
		.gprf_wr    (gprf_wr),
		.op_done    (op_done)
	);

	// data memory pins
	assign dat_mem1_en_b   = dmem_req.en_b;
	assign dat_mem1_rw     = dmem_req.rw;
	assign dat_mem1_addr   = dmem_req.addr;
	assign wrp_to_mem1_dat = dmem_req.wdat;

endmodule

// File: test/tcore_model.svh
/*
 * tcore reference model
 * instruction set executor and random program builders for the testbench
 */
`ifndef TCORE_MODEL_SVH
`define TCORE_MODEL_SVH

// model state
dat_t        m_reg [NUM_GPR];
dat_t        m_mem [256];
// one {addr, data} entry per store in program order
logic [23:0] exp_st [$];
// next free program word
imem_addr_t  wp;

// ------------------------------
// random fields
// ------------------------------
function automatic reg_idx_t rand_reg();
	return reg_idx_t'($urandom);
endfunction

function automatic imm_t rand_imm();
	return imm_t'($urandom);
endfunction

function automatic opcode_t rand_alu_opc();
	case ($urandom_range(0, 4))
		0: return OP_ADD;
		1: return OP_SUB;
		2: return OP_MUL;
		3: return OP_AND;
		default: return OP_XOR;
	endcase
endfunction

// ------------------------------
// program builders
// ------------------------------
// every word a halt tagged with its own address
task automatic clear_prog();
	for (int a = 0; a < 256; a++) begin
		prog[8'(a)] = {OP_HALT, 4'h0, 8'(a)};
	end
	wp = '0;
endtask

// immediate, data address or jump target form
task automatic put_imm(opcode_t opc, reg_idx_t rd, imm_t f);
	prog[wp] = {opc, rd, 1'b0, f};
	wp++;
endtask

// rd = rs op rt in register form
task automatic put_reg(opcode_t opc, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
	prog[wp] = {opc, rd, rs, rt, 3'b000};
	wp++;
endtask

task automatic gen_movi_st(int n);
	reg_idx_t r;
	clear_prog();
	repeat (n) begin
		r = rand_reg();
		put_imm(OP_MOVI, r, rand_imm());
		put_imm(OP_ST, r, rand_imm());
	end
	put_imm(OP_HALT, 3'd0, 8'h00);
endtask

// seed all registers, mix alu ops, then store every register at 0x80 up
task automatic gen_alu(int n, bit with_ld);
	clear_prog();
	for (int i = 0; i < NUM_GPR; i++) begin
		if (with_ld) begin
			put_imm(OP_LD, reg_idx_t'(i), rand_imm());
		end else begin
			put_imm(OP_MOVI, reg_idx_t'(i), rand_imm());
		end
	end
	repeat (n) begin
		put_reg(rand_alu_opc(), rand_reg(), rand_reg(), rand_reg());
	end
	for (int i = 0; i < NUM_GPR; i++) begin
		put_imm(OP_ST, reg_idx_t'(i), imm_t'(32'h80 + i));
	end
	put_imm(OP_HALT, 3'd0, 8'h00);
endtask

// forward jumps over stores that all target 0xf0 and up
task automatic gen_jmp(int segs);
	int skip;
	clear_prog();
	for (int i = 0; i < NUM_GPR; i++) begin
		put_imm(OP_MOVI, reg_idx_t'(i), rand_imm());
	end
	repeat (segs) begin
		skip = $urandom_range(1, 4);
		put_imm(OP_JMP, 3'd0, imm_t'(32'(wp) + 32'(skip) + 1));
		repeat (skip) begin
			put_imm(OP_ST, rand_reg(), 8'hf0 | imm_t'($urandom_range(0, 15)));
		end
		put_reg(rand_alu_opc(), rand_reg(), rand_reg(), rand_reg());
		put_imm(OP_ST, rand_reg(), imm_t'($urandom_range(0, 127)));
	end
	put_imm(OP_HALT, 3'd0, 8'h00);
endtask

// random mix with stray stores placed after the halt
task automatic gen_mixed(int n);
	clear_prog();
	for (int i = 0; i < NUM_GPR; i++) begin
		put_imm(OP_MOVI, reg_idx_t'(i), rand_imm());
	end
	repeat (n) begin
		case ($urandom_range(0, 2))
			0: put_reg(rand_alu_opc(), rand_reg(), rand_reg(), rand_reg());
			1: put_imm(OP_LD, rand_reg(), rand_imm());
			// live stores stay below 0xf0
			default: put_imm(OP_ST, rand_reg(), imm_t'($urandom_range(0, 239)));
		endcase
	end
	put_imm(OP_HALT, 3'd0, 8'h00);
	repeat (4) begin
		put_imm(OP_ST, rand_reg(), 8'hf0 | imm_t'($urandom_range(0, 15)));
	end
endtask

// ------------------------------
// executor
// ------------------------------
// runs prog from word 0 until halt by the opcode rules
task automatic model_run();
	imem_addr_t  pc;
	imem_addr_t  nxt;
	ins_t        w;
	reg_idx_t    rd;
	reg_idx_t    rs;
	reg_idx_t    rt;
	imm_t        f;
	logic [31:0] prod;
	bit          running;
	int          steps;
	pc      = '0;
	steps   = 0;
	running = 1'b1;
	exp_st.delete();
	for (int i = 0; i < NUM_GPR; i++) begin
		m_reg[reg_idx_t'(i)] = '0;
	end
	for (int a = 0; a < 256; a++) begin
		m_mem[8'(a)] = dmem_init[8'(a)];
	end
	while (running && steps < 2000) begin
		w   = prog[pc];
		rd  = w[11:9];
		rs  = w[8:6];
		rt  = w[5:3];
		f   = w[7:0];
		nxt = pc + 8'd1;
		steps++;
		case (opcode_t'(w[15:12]))
			OP_MOVI: m_reg[rd] = dat_t'(f);
			OP_LD:   m_reg[rd] = m_mem[f];
			OP_ST: begin
				m_mem[f] = m_reg[rd];
				exp_st.push_back({f, m_reg[rd]});
			end
			OP_ADD: m_reg[rd] = m_reg[rs] + m_reg[rt];
			OP_SUB: m_reg[rd] = m_reg[rs] - m_reg[rt];
			OP_MUL: begin
				// low half of the full product
				prod      = 32'(m_reg[rs]) * 32'(m_reg[rt]);
				m_reg[rd] = prod[15:0];
			end
			OP_AND:  m_reg[rd] = m_reg[rs] & m_reg[rt];
			OP_XOR:  m_reg[rd] = m_reg[rs] ^ m_reg[rt];
			OP_JMP:  nxt = f;
			OP_HALT: running = 1'b0;
			default: begin
				// nop and unused codes
			end
		endcase
		pc = nxt;
	end
endtask

`endif

// File: test/tcore_tb.sv
/*
 * tcore testbench
 * random programs on the core against an ISA model, memories modeled here
 */
module tcore_tb;
	import tcore_isa_pkg::*;

	logic       clk;
	logic       rst_n;
	logic       t_cs;
	ins_t       ins_mem_dat = '0;
	logic       ins_mem_en_b;
	imem_addr_t ins_mem_addr;
	logic       dat_mem1_rw;
	logic       dat_mem1_en_b;
	dmem_addr_t dat_mem1_addr;
	dat_t       mem1_to_wrp_dat = '0;
	dat_t       wrp_to_mem1_dat;
	logic       halt;

	// program image and data memory images
	ins_t        prog      [256];
	dat_t        dmem_init [256];
	dat_t        dmem      [256];
	// stores seen on the pins, {addr, data}
	logic [23:0] obs_st [$];

	string cur_test;
	int    errors;
	int    errs_base;
	int    tests_run;
	int    tests_failed;

	`include "tcore_model.svh"

	tcore_top uut (
		.clk             (clk),
		.rst_n           (rst_n),
		.t_cs            (t_cs),
		.ins_mem_dat     (ins_mem_dat),
		.ins_mem_en_b    (ins_mem_en_b),
		.ins_mem_addr    (ins_mem_addr),
		.dat_mem1_rw     (dat_mem1_rw),
		.dat_mem1_en_b   (dat_mem1_en_b),
		.dat_mem1_addr   (dat_mem1_addr),
		.mem1_to_wrp_dat (mem1_to_wrp_dat),
		.wrp_to_mem1_dat (wrp_to_mem1_dat),
		.halt            (halt)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// memory models
	// ------------------------------
	// instruction memory, data out the cycle after the strobe
	always @(posedge clk) begin
		if (!ins_mem_en_b) begin
			ins_mem_dat <= prog[ins_mem_addr];
		end
	end

	// data memory 1, reloaded from its image while in reset
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int a = 0; a < 256; a++) begin
				dmem[8'(a)] <= dmem_init[8'(a)];
			end
		end else if (!dat_mem1_en_b) begin
			if (dat_mem1_rw) begin
				mem1_to_wrp_dat <= dmem[dat_mem1_addr];
			end else begin
				dmem[dat_mem1_addr] <= wrp_to_mem1_dat;
			end
		end
	end

	// ------------------------------
	// checks and bookkeeping
	// ------------------------------
	function automatic void check_eq(string what, logic [23:0] exp, logic [23:0] act);
		assert (act === exp) else begin
			$display("ERROR %s: %s expected %0h actual %0h", cur_test, what, exp, act);
			errors++;
		end
	endfunction

	function automatic void check_idle(string where);
		check_eq({"ins_mem_en_b ", where}, 24'h1, 24'(ins_mem_en_b));
		check_eq({"dat_mem1_en_b ", where}, 24'h1, 24'(dat_mem1_en_b));
		check_eq({"halt ", where}, 24'h0, 24'(halt));
	endfunction

	task automatic start_test(string name);
		cur_test  = name;
		errs_base = errors;
	endtask

	task automatic finish_test();
		int errs;
		errs = errors - errs_base;
		tests_run++;
		if (errs == 0) begin
			$display("test %s: pass", cur_test);
		end else begin
			$display("test %s: FAIL with %0d errors", cur_test, errs);
			tests_failed++;
		end
	endtask

	task automatic fill_dmem(bit rnd);
		for (int a = 0; a < 256; a++) begin
			if (rnd) begin
				dmem_init[8'(a)] = dat_t'($urandom);
			end else begin
				dmem_init[8'(a)] = {~8'(a), 8'(a)};
			end
		end
	endtask

	// 16 cycles low, both strobes idle throughout and just after
	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		t_cs  <= 1'b1;
		repeat (16) begin
			@(negedge clk);
			check_idle("in reset");
		end
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_idle("after reset");
	endtask

	// model first, then the core until halt, then compare
	task automatic run_prog(bit cs_random);
		int cyc;
		int n;
		model_run();
		apply_reset();
		obs_st.delete();
		cyc = 0;
		while (halt !== 1'b1 && cyc < 20000) begin
			@(posedge clk);
			if (cs_random) begin
				t_cs <= ($urandom_range(0, 3) != 0);
			end
			@(negedge clk);
			if (t_cs === 1'b0) begin
				check_eq("fetch strobe with t_cs low", 24'h1, 24'(ins_mem_en_b));
			end
			if (dat_mem1_en_b === 1'b0 && dat_mem1_rw === 1'b0) begin
				obs_st.push_back({dat_mem1_addr, wrp_to_mem1_dat});
			end
			cyc++;
		end
		assert (halt === 1'b1) else begin
			$display("timeout in %s: halt did not rise within 20000 cycles", cur_test);
			errors++;
		end
		if (halt === 1'b1) begin
			@(posedge clk);
			t_cs <= 1'b1;
			// halted core stays silent
			repeat (50) begin
				@(negedge clk);
				check_eq("ins_mem_en_b after halt", 24'h1, 24'(ins_mem_en_b));
				check_eq("dat_mem1_en_b after halt", 24'h1, 24'(dat_mem1_en_b));
				check_eq("halt held", 24'h1, 24'(halt));
			end
		end
		check_eq("store count", 24'(exp_st.size()), 24'(obs_st.size()));
		n = (obs_st.size() < exp_st.size()) ? obs_st.size() : exp_st.size();
		for (int i = 0; i < n; i++) begin
			check_eq($sformatf("store %0d addr,data", i), exp_st[i], obs_st[i]);
		end
		for (int a = 0; a < 256; a++) begin
			check_eq($sformatf("dmem[%02h]", a), 24'(m_mem[8'(a)]), 24'(dmem[8'(a)]));
		end
	endtask

	// skipped stores all target 0xf0 and up
	task automatic check_no_skipped();
		foreach (obs_st[i]) begin
			assert (obs_st[i][23:20] != 4'hf) else begin
				$display("skipped store to %02h ran in %s", obs_st[i][23:16], cur_test);
				errors++;
			end
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		void'($urandom(32'h0fb8_cf22));
		rst_n        = 1'b0;
		t_cs         = 1'b1;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		clear_prog();
		fill_dmem(1'b0);

		start_test("reset");
		apply_reset();
		finish_test();

		start_test("movi_st");
		repeat (4) begin
			gen_movi_st(12);
			run_prog(1'b0);
		end
		finish_test();

		start_test("alu");
		repeat (4) begin
			gen_alu(30, 1'b0);
			run_prog(1'b0);
		end
		finish_test();

		start_test("load_alu");
		repeat (4) begin
			fill_dmem(1'b1);
			gen_alu(24, 1'b1);
			run_prog(1'b0);
		end
		finish_test();

		start_test("jump_cs");
		fill_dmem(1'b0);
		repeat (3) begin
			gen_jmp(6);
			run_prog(1'b1);
			check_no_skipped();
		end
		finish_test();

		start_test("halt");
		fill_dmem(1'b1);
		gen_mixed(40);
		run_prog(1'b0);
		check_no_skipped();
		finish_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+test
logic/tcore_isa_pkg.sv
logic/tcore_ctrl_pkg.sv
logic/ins_sequencer.sv
logic/ins_decoder.sv
logic/gprf.sv
logic/alu.sv
logic/mem_writeback.sv
logic/tcore_top.sv
test/tcore_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the tcore testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tcore_tb -o tcore_sim \
	&& ./obj_dir/tcore_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
exit 0
